// File: build.f
hw/video_pkg.sv
hw/video_if.sv
hw/video_timing.sv
hw/video_regs.sv
hw/bitmap_fetch.sv
hw/video_gen.sv
test/video_gen_props.sv
test/video_gen_tb.sv

// File: hw/bitmap_fetch.sv
// Bitmap fetch and pixel scan-out
`timescale 1ns/1ps

module bitmap_fetch import video_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    raster_if.sink             raster_i,
    display_cfg_if.sink        cfg_i,
    output logic               vram_sel_o,
    output logic [ADDR_W-1:0]  vram_addr_o,
    input  logic [DATA_W-1:0]  vram_data_i,
    output logic [COLOR_W-1:0] color_o
);

    // frame configuration
    logic [ADDR_W-1:0]       line_len;
    logic                    blank;
    logic [COLOR_W-PIXEL_W-1:0] colorbase_hi;
    logic [ADDR_W-1:0]       line_addr;         // first word of the current line

    logic [ADDR_W-1:0]       fetch_addr;
    logic [WORD_CNT_W-1:0]   fetch_left;        // words still to request
    logic [PHASE_W-1:0]      fetch_phase;
    logic                    fetch_start;
    logic                    fetch_step;
    logic                    data_valid;        // vram_data_i holds a word this cycle
    logic [DATA_W-1:0]       word_buf [2];
    logic                    wr_slot;

    logic [LEAD_W-1:0]       lead_cnt;          // cycles until the first visible pixel
    logic [PHASE_W-1:0]      pix_phase;
    logic                    rd_slot;
    logic [DATA_W-1:0]       pix_shift;
    logic                    load_word;
    logic                    visible;

    assign visible     = (raster_i.h_state == VISIBLE) && (raster_i.v_state == VISIBLE);
    assign fetch_start = raster_i.line_fetch && !blank;
    assign fetch_step  = (fetch_left != '0) && (fetch_phase == PHASE_W'(PIXELS_PER_WORD - 1));
    assign load_word   = (lead_cnt == LEAD_W'(1)) ||
                         (visible && pix_phase == PHASE_W'(PIXELS_PER_WORD - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o   <= 1'b0;
            data_valid   <= 1'b0;
            fetch_left   <= '0;
            fetch_phase  <= '0;
            wr_slot      <= 1'b0;
            rd_slot      <= 1'b0;
            lead_cnt     <= '0;
            pix_phase    <= '0;
            line_addr    <= '0;
            line_len     <= ADDR_W'(WORDS_PER_LINE);
            blank        <= 1'b0;
            colorbase_hi <= '0;
        end else begin
            vram_sel_o  <= fetch_start || fetch_step;
            data_valid  <= vram_sel_o;          // fixed one cycle read latency
            fetch_phase <= fetch_phase + 1'b1;
            if (data_valid) begin
                wr_slot <= ~wr_slot;
            end
            if (load_word) begin
                rd_slot <= ~rd_slot;
            end
            if (fetch_start) begin
                fetch_left  <= WORD_CNT_W'(WORDS_PER_LINE - 1);
                fetch_phase <= '0;
                wr_slot     <= 1'b0;
                rd_slot     <= 1'b0;
                lead_cnt    <= LEAD_W'(FETCH_LEAD - 1);
            end else begin
                if (fetch_step) begin
                    fetch_left <= fetch_left - 1'b1;
                end
                if (lead_cnt != '0) begin
                    lead_cnt <= lead_cnt - 1'b1;
                end
            end
            if (lead_cnt == LEAD_W'(1)) begin
                pix_phase <= '0;                // first word goes to the shifter
            end else if (visible) begin
                pix_phase <= pix_phase + 1'b1;
            end
            // new configuration only takes effect between frames
            if (raster_i.frame_end) begin
                line_addr    <= cfg_i.start_addr;
                line_len     <= cfg_i.line_len;
                blank        <= cfg_i.blank;
                colorbase_hi <= cfg_i.colorbase[COLOR_W-1 -: COLOR_W-PIXEL_W];
            end else if (raster_i.line_end) begin
                line_addr <= line_addr + line_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            vram_addr_o <= line_addr;
            fetch_addr  <= line_addr + 1'b1;
        end else if (fetch_step) begin
            vram_addr_o <= fetch_addr;
            fetch_addr  <= fetch_addr + 1'b1;
        end
        if (data_valid) begin
            word_buf[wr_slot] <= vram_data_i;
        end
        if (load_word) begin
            pix_shift <= word_buf[rd_slot];
        end else if (visible) begin
            pix_shift <= pix_shift << PIXEL_W;  // msb nibble is the leftmost pixel
        end
    end

    assign color_o = (visible && !blank) ? {colorbase_hi, pix_shift[DATA_W-1 -: PIXEL_W]}
                                         : cfg_i.border_color;

endmodule

// File: hw/video_gen.sv
// Bitmap video generator top level
`timescale 1ns/1ps

module video_gen import video_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    // register port
    input  logic                 reg_wr_i,
    input  logic [REG_NUM_W-1:0] reg_num_i,
    input  logic [DATA_W-1:0]    reg_data_i,
    output logic [DATA_W-1:0]    reg_data_o,
    input  logic [INTR_W-1:0]    intr_status_i,
    output logic [INTR_W-1:0]    intr_signal_o,
    // vram read port
    output logic                 vram_sel_o,
    output logic [ADDR_W-1:0]    vram_addr_o,
    input  logic [DATA_W-1:0]    vram_data_i,
    // video out
    output logic [COLOR_W-1:0]   color_index_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 dv_de_o
);

    raster_if      raster ();
    display_cfg_if cfg ();

    logic [COLOR_W-1:0] color;

    video_timing u_timing (
        .clk      (clk),
        .reset_i  (reset_i),
        .raster_o (raster)
    );

    video_regs u_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (reg_wr_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .reg_data_o    (reg_data_o),
        .intr_status_i (intr_status_i),
        .intr_signal_o (intr_signal_o),
        .raster_i      (raster),
        .cfg_o         (cfg)
    );

    bitmap_fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .raster_i    (raster),
        .cfg_i       (cfg),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_i (vram_data_i),
        .color_o     (color)
    );

    // sync, enable and colour all sample the same counter state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o <= ~H_SYNC_POLARITY;
            vsync_o <= ~V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            hsync_o <= (raster.h_state == SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (raster.v_state == SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o <= (raster.h_state == VISIBLE) && (raster.v_state == VISIBLE);
        end
    end

    always_ff @(posedge clk) begin
        color_index_o <= color;
    end

endmodule

// File: hw/video_if.sv
// Raster and display configuration interfaces
`timescale 1ns/1ps

interface raster_if import video_pkg::*; ();
    logic [COUNT_W-1:0] h_count;
    logic [COUNT_W-1:0] v_count;
    video_state_e       h_state;
    video_state_e       v_state;
    logic               line_fetch;     // FETCH_LEAD pixels before a visible line
    logic               line_end;       // last visible pixel of a visible line
    logic               frame_end;      // last pixel of the frame
    logic               vblank;         // last visible pixel of the frame

    modport source (
        output h_count, v_count, h_state, v_state,
        output line_fetch, line_end, frame_end, vblank
    );
    modport sink (
        input h_count, v_count, h_state, v_state,
        input line_fetch, line_end, frame_end, vblank
    );
endinterface

interface display_cfg_if import video_pkg::*; ();
    logic [COLOR_W-1:0] colorbase;
    logic               blank;
    logic [ADDR_W-1:0]  start_addr;
    logic [ADDR_W-1:0]  line_len;       // words per line
    logic [COLOR_W-1:0] border_color;

    modport source (output colorbase, blank, start_addr, line_len, border_color);
    modport sink (input colorbase, blank, start_addr, line_len, border_color);
endinterface

// File: hw/video_pkg.sv
// Video generator definitions

package video_pkg;

    // horizontal mode, in pixels
    localparam int VISIBLE_WIDTH   = 32;
    localparam int H_FRONT_PORCH   = 4;
    localparam int H_SYNC_PULSE    = 4;
    localparam int H_BACK_PORCH    = 8;
    localparam int OFFSCREEN_WIDTH = H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int TOTAL_WIDTH     = OFFSCREEN_WIDTH + VISIBLE_WIDTH;   // 48

    // vertical mode, in lines
    localparam int VISIBLE_HEIGHT  = 6;
    localparam int V_FRONT_PORCH   = 1;
    localparam int V_SYNC_PULSE    = 2;
    localparam int V_BACK_PORCH    = 1;
    localparam int TOTAL_HEIGHT    = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    localparam logic H_SYNC_POLARITY = 1'b0;                // negative sync
    localparam logic V_SYNC_POLARITY = 1'b0;

    // bitmap layout and fetch
    localparam int PIXELS_PER_WORD = 4;
    localparam int FETCH_LEAD      = 8;                     // fetch starts this many pixels early
    localparam int WORDS_PER_LINE  = VISIBLE_WIDTH / PIXELS_PER_WORD;

    // field widths
    localparam int COUNT_W    = 11;
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 16;
    localparam int COLOR_W    = 8;
    localparam int REG_NUM_W  = 5;
    localparam int INTR_W     = 4;
    localparam int PIXEL_W    = DATA_W / PIXELS_PER_WORD;   // 4 bpp
    localparam int PHASE_W    = $clog2(PIXELS_PER_WORD);
    localparam int WORD_CNT_W = $clog2(WORDS_PER_LINE + 1);
    localparam int LEAD_W     = $clog2(FETCH_LEAD);

    localparam int INTR_VBLANK = 3;

    // same sequence for both axes
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } video_state_e;

    typedef enum logic [REG_NUM_W-1:0] {
        XR_VID_CTRL     = 5'd0,
        XR_SCANLINE     = 5'd4,     // read only
        XR_VID_HSIZE    = 5'd5,     // read only
        XR_VID_VSIZE    = 5'd6,     // read only
        XR_PA_GFX_CTRL  = 5'd8,
        XR_PA_DISP_ADDR = 5'd10,
        XR_PA_LINE_LEN  = 5'd11
    } xr_reg_e;

endpackage

// File: hw/video_regs.sv
// Video configuration registers
`timescale 1ns/1ps

module video_regs import video_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reg_wr_i,
    input  logic [REG_NUM_W-1:0] reg_num_i,
    input  logic [DATA_W-1:0]    reg_data_i,
    output logic [DATA_W-1:0]    reg_data_o,
    input  logic [INTR_W-1:0]    intr_status_i,
    output logic [INTR_W-1:0]    intr_signal_o,
    raster_if.sink               raster_i,
    display_cfg_if.source        cfg_o
);

    logic [COLOR_W-1:0] border_color;
    logic [COLOR_W-1:0] colorbase;
    logic               blank;
    logic [ADDR_W-1:0]  start_addr;
    logic [ADDR_W-1:0]  line_len;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= '0;
            border_color  <= '0;
            colorbase     <= '0;
            blank         <= 1'b0;
            start_addr    <= '0;
            line_len      <= ADDR_W'(WORDS_PER_LINE);  // one visible line of 4 bpp
        end else begin
            intr_signal_o <= '0;                        // strobes last one cycle
            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        border_color  <= reg_data_i[15:8];
                        intr_signal_o <= reg_data_i[INTR_W-1:0];
                    end
                    XR_PA_GFX_CTRL: begin
                        colorbase <= reg_data_i[15:8];
                        blank     <= reg_data_i[7];
                    end
                    XR_PA_DISP_ADDR: start_addr <= reg_data_i;
                    XR_PA_LINE_LEN:  line_len   <= reg_data_i;
                    default: ;                          // read only or unused
                endcase
            end
            if (raster_i.vblank) begin
                intr_signal_o[INTR_VBLANK] <= 1'b1;
            end
        end
    end

    // read data is registered, valid the cycle after the number
    always_ff @(posedge clk) begin
        case (reg_num_i)
            XR_VID_CTRL:
                reg_data_o <= {border_color, {(DATA_W-COLOR_W-INTR_W){1'b0}}, intr_status_i};
            XR_SCANLINE:
                reg_data_o <= {raster_i.v_state != VISIBLE, raster_i.h_state != VISIBLE,
                               {(DATA_W-COUNT_W-2){1'b0}}, raster_i.v_count};
            XR_VID_HSIZE:    reg_data_o <= DATA_W'(VISIBLE_WIDTH);
            XR_VID_VSIZE:    reg_data_o <= DATA_W'(VISIBLE_HEIGHT);
            XR_PA_GFX_CTRL:  reg_data_o <= {colorbase, blank, {(DATA_W-COLOR_W-1){1'b0}}};
            XR_PA_DISP_ADDR: reg_data_o <= start_addr;
            XR_PA_LINE_LEN:  reg_data_o <= line_len;
            default:         reg_data_o <= '0;
        endcase
    end

    assign cfg_o.border_color = border_color;
    assign cfg_o.colorbase    = colorbase;
    assign cfg_o.blank        = blank;
    assign cfg_o.start_addr   = start_addr;
    assign cfg_o.line_len     = line_len;

endmodule

// File: hw/video_timing.sv
// Raster timing generator
`timescale 1ns/1ps

module video_timing import video_pkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    raster_if.source raster_o
);

    logic [COUNT_W-1:0] h_count;
    logic [COUNT_W-1:0] v_count;
    logic [COUNT_W-1:0] h_limit;        // last count of the current state
    logic [COUNT_W-1:0] v_limit;
    video_state_e       h_state;
    video_state_e       v_state;
    logic               h_last;         // last pixel of any line
    logic               frame_end;

    function automatic video_state_e next_state(input video_state_e state);
        case (state)
            PRE_SYNC:  next_state = SYNC;
            SYNC:      next_state = POST_SYNC;
            POST_SYNC: next_state = VISIBLE;
            default:   next_state = PRE_SYNC;
        endcase
    endfunction

    // offscreen pixels come first, so the visible area ends each line
    always_comb begin
        case (h_state)
            PRE_SYNC:  h_limit = COUNT_W'(H_FRONT_PORCH - 1);
            SYNC:      h_limit = COUNT_W'(H_FRONT_PORCH + H_SYNC_PULSE - 1);
            POST_SYNC: h_limit = COUNT_W'(OFFSCREEN_WIDTH - 1);
            default:   h_limit = COUNT_W'(TOTAL_WIDTH - 1);
        endcase
    end

    // visible lines first, blanking at the bottom
    always_comb begin
        case (v_state)
            VISIBLE:   v_limit = COUNT_W'(VISIBLE_HEIGHT - 1);
            PRE_SYNC:  v_limit = COUNT_W'(VISIBLE_HEIGHT + V_FRONT_PORCH - 1);
            SYNC:      v_limit = COUNT_W'(VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1);
            default:   v_limit = COUNT_W'(TOTAL_HEIGHT - 1);
        endcase
    end

    assign h_last    = (h_state == VISIBLE) && (h_count == h_limit);
    assign frame_end = h_last && (v_state == POST_SYNC) && (v_count == v_limit);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= PRE_SYNC;                    // first frame starts in blanking
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_count == h_limit) begin
                h_state <= next_state(h_state);
            end
            if (h_last && (v_count == v_limit)) begin
                v_state <= next_state(v_state);
            end
            if (h_last) begin
                h_count <= '0;
                v_count <= frame_end ? '0 : v_count + 1'b1;
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    assign raster_o.h_count    = h_count;
    assign raster_o.v_count    = v_count;
    assign raster_o.h_state    = h_state;
    assign raster_o.v_state    = v_state;
    assign raster_o.line_fetch = (v_state == VISIBLE) &&
                                 (h_count == COUNT_W'(OFFSCREEN_WIDTH - FETCH_LEAD));
    assign raster_o.line_end   = h_last && (v_state == VISIBLE);
    assign raster_o.frame_end  = frame_end;
    assign raster_o.vblank     = raster_o.line_end && (v_count == v_limit);

endmodule

// File: run.sh
#!/bin/sh
# build and run the video generator simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module video_gen_tb -f build.f -o video_gen_sim
./obj_dir/video_gen_sim

// File: test/video_gen_props.sv
// Raster timing assertions
`timescale 1ns/1ps

module video_gen_props import video_pkg::*; (
    input logic clk,
    input logic reset_i,
    input logic hsync_o,
    input logic vsync_o,
    input logic dv_de_o,
    input logic vram_sel_o
);

    logic [7:0] run_cycles;     // cycles since reset, saturating
    logic       warm;
    logic       hs_act;
    logic       vs_act;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_cycles <= '0;
        end else if (run_cycles != '1) begin
            run_cycles <= run_cycles + 1'b1;
        end
    end

    assign warm   = run_cycles > 8'(2 * TOTAL_WIDTH);  // history is past reset
    assign hs_act = (hsync_o == H_SYNC_POLARITY);
    assign vs_act = (vsync_o == V_SYNC_POLARITY);

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        warm && $fell(hs_act) |-> $past(hs_act, H_SYNC_PULSE) && !$past(hs_act, H_SYNC_PULSE + 1))
        else $error("hsync pulse is not H_SYNC_PULSE cycles long");

    hsync_period: assert property (@(posedge clk) disable iff (reset_i)
        warm && $rose(hs_act) |-> $past(hs_act, TOTAL_WIDTH) && !$past(hs_act, TOTAL_WIDTH + 1))
        else $error("hsync period is not TOTAL_WIDTH cycles");

    de_width: assert property (@(posedge clk) disable iff (reset_i)
        warm && $fell(dv_de_o) |-> $past(dv_de_o, VISIBLE_WIDTH)
                                   && !$past(dv_de_o, VISIBLE_WIDTH + 1))
        else $error("display enable run is not VISIBLE_WIDTH cycles long");

    vsync_width: assert property (@(posedge clk) disable iff (reset_i)
        warm && $fell(vs_act) |-> $past(vs_act, V_SYNC_PULSE * TOTAL_WIDTH)
                                  && !$past(vs_act, V_SYNC_PULSE * TOTAL_WIDTH + 1))
        else $error("vsync pulse is not V_SYNC_PULSE lines long");

    no_fetch_in_vsync: assert property (@(posedge clk) disable iff (reset_i)
        vs_act |-> !vram_sel_o)
        else $error("vram read issued during vertical sync");

endmodule

bind video_gen video_gen_props u_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .hsync_o    (hsync_o),
    .vsync_o    (vsync_o),
    .dv_de_o    (dv_de_o),
    .vram_sel_o (vram_sel_o)
);

// File: test/video_gen_tb.sv
// Video generator testbench
`timescale 1ns/1ps

module video_gen_tb import video_pkg::*; ();

    logic                 clk = 1'b0;
    logic                 reset_i;
    logic                 reg_wr_i;
    logic [REG_NUM_W-1:0] reg_num_i;
    logic [DATA_W-1:0]    reg_data_i;
    logic [DATA_W-1:0]    reg_data_o;
    logic [INTR_W-1:0]    intr_status_i;
    logic [INTR_W-1:0]    intr_signal_o;
    logic                 vram_sel_o;
    logic [ADDR_W-1:0]    vram_addr_o;
    logic [DATA_W-1:0]    vram_data_i;
    logic [COLOR_W-1:0]   color_index_o;
    logic                 hsync_o;
    logic                 vsync_o;
    logic                 dv_de_o;

    logic [DATA_W-1:0]    vram [65536];

    // register contents as written
    logic [ADDR_W-1:0]    sh_addr = '0;
    logic [ADDR_W-1:0]    sh_len = ADDR_W'(VISIBLE_WIDTH / PIXELS_PER_WORD);
    logic [COLOR_W-1:0]   sh_base = '0;
    logic                 sh_blank = 1'b0;
    logic [COLOR_W-1:0]   sh_border = '0;
    // configuration of the frame being scanned
    logic [ADDR_W-1:0]    f_addr;
    logic [ADDR_W-1:0]    f_len;
    logic [COLOR_W-1:0]   f_base;
    logic                 f_blank = 1'b0;
    logic [COLOR_W-1:0]   exp_color;

    int   x = 0;                                // pixel within the current run
    int   y = 0;                                // visible line within the frame
    int   frame_no = 0;
    int   vblank_cnt = 0;
    int   hs_run = 0;                           // cycles of the current hsync pulse
    int   hs_period = 0;                        // cycles since the last hsync start
    int   hs_pulses = 0;
    int   vs_run = 0;
    logic prev_de = 1'b0;
    logic prev_vs = 1'b0;
    logic prev_hs = 1'b0;

    video_gen u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram[vram_addr_o];   // one cycle read latency
        end
    end

    function automatic logic [COLOR_W-1:0] expected_color(input int px, input int py,
            input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] len,
            input logic [COLOR_W-1:0] cbase);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] word;
        int                nib;
        addr = base + ADDR_W'(py) * len + ADDR_W'(px / PIXELS_PER_WORD);
        word = vram[addr];
        nib  = PIXELS_PER_WORD - 1 - (px % PIXELS_PER_WORD);  // msb nibble is leftmost
        return {cbase[COLOR_W-1 -: COLOR_W-PIXEL_W], word[nib * PIXEL_W +: PIXEL_W]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_failure(input string reason);
        $display("timeout: %s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (!reset_i) begin
            hs_period = hs_period + 1;
            if (hsync_o == H_SYNC_POLARITY) begin
                if (!prev_hs) begin                 // start of a line sync pulse
                    if (hs_pulses > 0) begin
                        check_value("hsync_o period", 32'(TOTAL_WIDTH), 32'(hs_period));
                    end
                    hs_pulses = hs_pulses + 1;
                    hs_period = 0;
                end
                hs_run = hs_run + 1;
            end else if (prev_hs) begin
                check_value("hsync_o pulse length", 32'(H_SYNC_PULSE), 32'(hs_run));
                hs_run = 0;
            end
            if (vsync_o == V_SYNC_POLARITY) begin
                vs_run = vs_run + 1;
            end else if (prev_vs) begin
                check_value("vsync_o pulse length", 32'(V_SYNC_PULSE * TOTAL_WIDTH),
                            32'(vs_run));
                vs_run = 0;
            end
            if ((vsync_o == V_SYNC_POLARITY) && !prev_vs) begin   // new frame
                if (frame_no > 0) begin
                    check_value("dv_de_o lines per frame", 32'(VISIBLE_HEIGHT), 32'(y));
                    check_value("intr_signal_o vblank pulses", 32'd1, 32'(vblank_cnt));
                end
                frame_no = frame_no + 1;
                y = 0;
                vblank_cnt = 0;
                f_addr = sh_addr;
                f_len = sh_len;
                f_base = sh_base;
                f_blank = sh_blank;
            end
            if (dv_de_o) begin
                exp_color = f_blank ? sh_border : expected_color(x, y, f_addr, f_len, f_base);
                check_value("color_index_o", 32'(exp_color), 32'(color_index_o));
                x = x + 1;
            end else if (prev_de) begin
                check_value("dv_de_o run length", 32'(VISIBLE_WIDTH), 32'(x));
                x = 0;
                y = y + 1;
            end
            if (intr_signal_o[INTR_VBLANK]) begin   // due on the last visible pixel
                vblank_cnt = vblank_cnt + 1;
                check_value("intr_signal_o vblank position",
                            32'(VISIBLE_WIDTH * VISIBLE_HEIGHT), 32'(y * VISIBLE_WIDTH + x));
            end
            if (f_blank) begin
                check_value("vram_sel_o", 32'd0, 32'(vram_sel_o));
            end
            prev_de = dv_de_o;
            prev_vs = (vsync_o == V_SYNC_POLARITY);
            prev_hs = (hsync_o == H_SYNC_POLARITY);
        end
    end

    task automatic write_reg(input logic [REG_NUM_W-1:0] num, input logic [DATA_W-1:0] data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= num;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
        case (num)
            XR_VID_CTRL: sh_border = data[15:8];
            XR_PA_GFX_CTRL: begin
                sh_base  = data[15:8];
                sh_blank = data[7];
            end
            XR_PA_DISP_ADDR: sh_addr = data;
            XR_PA_LINE_LEN:  sh_len = data;
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [REG_NUM_W-1:0] num, input logic [DATA_W-1:0] expected);
        @(posedge clk);
        reg_num_i <= num;
        @(posedge clk);
        @(negedge clk);                         // registered one cycle after the number
        check_value("reg_data_o", 32'(expected), 32'(reg_data_o));
    endtask

    task automatic wait_frames(input int count);
        int target;
        int cycles;
        target = frame_no + count;
        cycles = 0;
        while (frame_no < target) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > (count + 1) * TOTAL_WIDTH * TOTAL_HEIGHT) begin
                stop_with_failure("no vertical sync within the expected frame time");
            end
        end
    endtask

    task automatic wait_visible();
        int cycles;
        cycles = 0;
        while (!dv_de_o) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > TOTAL_WIDTH * TOTAL_HEIGHT) begin
                stop_with_failure("display enable never went high");
            end
        end
    endtask

    initial begin
        void'($urandom(85));
        for (int i = 0; i < 65536; i++) begin
            vram[i] = DATA_W'($urandom());
        end
        reset_i       = 1'b1;
        reg_wr_i      = 1'b0;
        reg_num_i     = '0;
        reg_data_i    = '0;
        intr_status_i = 4'h6;
        vram_data_i   = '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        read_reg(XR_VID_HSIZE, DATA_W'(VISIBLE_WIDTH));
        read_reg(XR_VID_VSIZE, DATA_W'(VISIBLE_HEIGHT));
        read_reg(XR_PA_LINE_LEN, 16'd8);
        wait_frames(2);                         // a whole frame on the reset configuration

        // new layout, effective from the next frame
        wait_visible();
        write_reg(XR_PA_GFX_CTRL, 16'hA500);
        write_reg(XR_PA_DISP_ADDR, 16'h0123);
        write_reg(XR_PA_LINE_LEN, 16'd11);
        read_reg(XR_PA_GFX_CTRL, 16'hA500);
        read_reg(XR_PA_DISP_ADDR, 16'h0123);
        read_reg(XR_PA_LINE_LEN, 16'd11);
        wait_frames(2);

        // border colour with a write-triggered interrupt, then blank the plane
        wait_visible();
        write_reg(XR_VID_CTRL, 16'h3C05);
        @(negedge clk);
        check_value("intr_signal_o", 32'h5, 32'(intr_signal_o));
        @(negedge clk);
        check_value("intr_signal_o", 32'h0, 32'(intr_signal_o));
        read_reg(XR_VID_CTRL, 16'h3C06);
        write_reg(XR_PA_GFX_CTRL, 16'hA580);
        wait_frames(2);

        $display("All checks passed");
        $finish;
    end

endmodule
